// ==== all.f ====
source/profiler_pkg.sv
source/reset_hold.sv
source/activity_sampler.sv
source/activity_counters.sv
source/average_unit.sv
source/core_profiler.sv
verif/core_profiler_properties.sv
verif/tb_core_profiler.sv

// ==== Bender.yml ====
package:
  name: core_profiler

sources:
  - files:
      - source/profiler_pkg.sv
      - source/reset_hold.sv
      - source/activity_sampler.sv
      - source/activity_counters.sv
      - source/average_unit.sv
      - source/core_profiler.sv

  - target: test
    files:
      - verif/core_profiler_properties.sv
      - verif/tb_core_profiler.sv

// ==== verif/tb_core_profiler.sv ====
// core profiler testbench

`timescale 1ns/1ps

module tb_core_profiler;
    import profiler_pkg::*;

    //////////////////////////////////////////////////
    // run lengths
    //////////////////////////////////////////////////

    localparam int RESET_CYCLES   = 4;
    localparam int ACT_CYCLES     = 160;
    localparam int STAGGER_CYCLES = 24;
    localparam int HALT_WINDOW    = 8;
    // per source two pulse lengths, each with hold and a short gap
    localparam int STRETCH_CYCLES = 6 * (3 + HOLD_CYCLES + 4);
    // four activity runs each followed by a halting phase
    localparam int MAX_CYCLES = RESET_CYCLES + HOLD_CYCLES + STRETCH_CYCLES
                              + 4 * (ACT_CYCLES + STAGGER_CYCLES + HALT_WINDOW) + 100;

    logic       clk;
    logic       reset;
    logic       wdreset;
    logic       bus_err;
    core_mask_t bus_sel;
    core_mask_t fetch_sel;
    core_mask_t halt;
    logic       soft_reset;
    logic       all_halted;
    logic       avg_valid;
    count_t     bus_time_avg;
    count_t     bus_req_avg;
    count_t     fetch_time_avg;
    count_t     work_time_avg;

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    logic        checking    = 1'b0;
    logic [31:0] lfsr;

    // reference model state
    int         m_hold = 0;
    logic       m_soft = 1'b0;
    logic       m_ha = 1'b0;
    core_mask_t m_prev_bus = '0;
    int         m_bus[CORES];
    int         m_req[CORES];
    int         m_fetch[CORES];
    int         m_work[CORES];
    int         pend = 0;
    int         pend_avg[4];
    int         exp_avg[4];
    logic       exp_valid = 1'b0;

    core_profiler u_dut (
        .clk            (clk),
        .reset          (reset),
        .wdreset        (wdreset),
        .bus_err        (bus_err),
        .bus_sel        (bus_sel),
        .fetch_sel      (fetch_sel),
        .halt           (halt),
        .soft_reset     (soft_reset),
        .all_halted     (all_halted),
        .avg_valid      (avg_valid),
        .bus_time_avg   (bus_time_avg),
        .bus_req_avg    (bus_req_avg),
        .fetch_time_avg (fetch_time_avg),
        .work_time_avg  (work_time_avg)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no verdict after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // random source and checking
    //////////////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int floor_avg(input int cnt[CORES]);
        int sum;
        sum = 0;
        for (int i = 0; i < CORES; i++) begin
            sum += cnt[i];
        end
        return sum / CORES;
    endfunction

    //////////////////////////////////////////////////
    // reference model stepped once per rising edge
    //////////////////////////////////////////////////

    task automatic model_edge();
        logic       soft_old;
        logic       live;
        logic       ha_new;
        core_mask_t req;
        soft_old = m_soft;
        // cycle is sampled only when the soft reset was low at its edge
        live = !soft_old;
        if (reset || wdreset || bus_err) begin
            m_hold = HOLD_CYCLES - 1;
        end
        else if (m_hold > 0) begin
            m_hold--;
        end
        m_soft = (m_hold > 0);

        // averages land two edges after the halting cycle
        exp_valid = 1'b0;
        if (soft_old) begin
            pend = 0;
            exp_avg = '{default: 0};
        end
        else if (pend > 0) begin
            pend--;
            if (pend == 0) begin
                exp_valid = 1'b1;
                exp_avg = pend_avg;
            end
        end

        req = live ? (bus_sel & ~m_prev_bus) : '0;
        ha_new = live && (&halt);
        for (int c = 0; c < CORES; c++) begin
            if (m_soft) begin
                m_bus[c]   = 0;
                m_req[c]   = 0;
                m_fetch[c] = 0;
                m_work[c]  = 0;
            end
            else if (live) begin
                m_bus[c]   += bus_sel[c];
                m_req[c]   += req[c];
                m_fetch[c] += fetch_sel[c];
                // work only with no bus, no fetch and no halt
                m_work[c]  += !(bus_sel[c] || fetch_sel[c] || halt[c]);
            end
        end
        if (ha_new && !m_ha && !m_soft) begin
            pend = 2;
            pend_avg[0] = floor_avg(m_bus);
            pend_avg[1] = floor_avg(m_req);
            pend_avg[2] = floor_avg(m_fetch);
            pend_avg[3] = floor_avg(m_work);
        end
        m_prev_bus = live ? bus_sel : '0;
        m_ha = ha_new;
    endtask

    task automatic compare_outputs();
        check_value("soft_reset", soft_reset, m_soft);
        check_value("all_halted", all_halted, m_ha);
        check_value("avg_valid", avg_valid, exp_valid);
        check_value("bus_time_avg", bus_time_avg, exp_avg[0]);
        check_value("bus_req_avg", bus_req_avg, exp_avg[1]);
        check_value("fetch_time_avg", fetch_time_avg, exp_avg[2]);
        check_value("work_time_avg", work_time_avg, exp_avg[3]);
    endtask

    // inputs change on the falling edge only
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        model_edge();
        if (checking) begin
            compare_outputs();
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus phases
    //////////////////////////////////////////////////

    task automatic stretch_pulse(input int source, input int len);
        int held;
        held = 0;
        for (int i = 0; i < len; i++) begin
            reset   = (source == 0);
            wdreset = (source == 1);
            bus_err = (source == 2);
            next_cycle();
        end
        reset   = 1'b0;
        wdreset = 1'b0;
        bus_err = 1'b0;
        // edges from the last source edge until the drop
        do begin
            next_cycle();
            held++;
        end while (soft_reset);
        check_value("soft_reset hold length", held, HOLD_CYCLES - 1);
        repeat (4) next_cycle();
    endtask

    task automatic run_activity(input int cycles, input logic use_fetch,
                                input logic use_halt);
        core_mask_t h;
        for (int i = 0; i < cycles; i++) begin
            bus_sel   = core_mask_t'(random_bits(CORES));
            fetch_sel = use_fetch ? core_mask_t'(random_bits(CORES)) : '0;
            h = use_halt ? core_mask_t'(random_bits(CORES) & random_bits(CORES)) : '0;
            // keep one core running
            if (&h) begin
                h[0] = 1'b0;
            end
            halt = h;
            next_cycle();
        end
    endtask

    task automatic halt_cores(input logic use_fetch, output int pulses);
        core_mask_t h;
        h = '0;
        for (int i = 0; i < STAGGER_CYCLES && !(&h); i++) begin
            h = h | core_mask_t'(random_bits(CORES) & random_bits(CORES));
            bus_sel   = core_mask_t'(random_bits(CORES)) & ~h;
            fetch_sel = use_fetch ? (core_mask_t'(random_bits(CORES)) & ~h) : '0;
            halt = h;
            next_cycle();
        end
        // stragglers halt now
        bus_sel   = '0;
        fetch_sel = '0;
        halt      = '1;
        pulses = 0;
        repeat (HALT_WINDOW) begin
            next_cycle();
            if (avg_valid) begin
                pulses++;
            end
        end
    endtask

    initial begin
        int pulses;
        int held_avg[4];
        lfsr      = 32'hd226;
        reset     = 1'b1;
        wdreset   = 1'b0;
        bus_err   = 1'b0;
        bus_sel   = '0;
        fetch_sel = '0;
        halt      = '0;
        repeat (RESET_CYCLES) next_cycle();
        reset    = 1'b0;
        checking = 1'b1;
        while (soft_reset) begin
            next_cycle();
        end

        for (int s = 0; s < 3; s++) begin
            stretch_pulse(s, 1);
            stretch_pulse(s, 3);
        end

        // bus traffic only
        run_activity(ACT_CYCLES, 1'b0, 1'b0);
        halt_cores(1'b0, pulses);
        check_value("avg_valid pulses, bus phase", pulses, 1);

        // fetch and staggered halts
        run_activity(ACT_CYCLES, 1'b1, 1'b1);
        halt_cores(1'b1, pulses);
        check_value("avg_valid pulses, fetch phase", pulses, 1);
        held_avg = exp_avg;

        // second period adds to the first
        run_activity(ACT_CYCLES, 1'b1, 1'b1);
        check_value("held bus_time_avg", bus_time_avg, held_avg[0]);
        check_value("held bus_req_avg", bus_req_avg, held_avg[1]);
        check_value("held fetch_time_avg", fetch_time_avg, held_avg[2]);
        check_value("held work_time_avg", work_time_avg, held_avg[3]);
        halt_cores(1'b1, pulses);
        check_value("avg_valid pulses, cumulative", pulses, 1);

        // bus error mid-run clears the counts
        run_activity(ACT_CYCLES / 2, 1'b1, 1'b1);
        bus_err = 1'b1;
        next_cycle();
        bus_err = 1'b0;
        run_activity(ACT_CYCLES / 2, 1'b1, 1'b1);
        halt_cores(1'b1, pulses);
        check_value("avg_valid pulses, after clear", pulses, 1);

        $display("checks: %0d, errors: %0d, assertion errors: %0d",
                 checks, errors, u_dut.u_props.assert_errors);
        if (errors == 0 && u_dut.u_props.assert_errors == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/core_profiler_properties.sv ====
// core profiler port assertions

`timescale 1ns/1ps

module core_profiler_properties (
    input clk,
    input reset,
    input wdreset,
    input bus_err,
    input soft_reset,
    input avg_valid
);
    // failures seen by the assertions below
    int assert_errors = 0;

    // averages come as a single-cycle strobe
    property p_valid_one_cycle;
        @(posedge clk) disable iff (reset) avg_valid |=> !avg_valid;
    endproperty

    property p_no_valid_in_reset;
        @(posedge clk) disable iff (reset) avg_valid |-> !soft_reset;
    endproperty

    // any source opens the hold window on the next edge
    property p_source_holds;
        @(posedge clk) (reset || wdreset || bus_err) |=> soft_reset;
    endproperty

    a_valid_one_cycle: assert property (p_valid_one_cycle)
    else begin
        assert_errors++;
        $error("avg_valid high for two cycles");
    end

    a_no_valid_in_reset: assert property (p_no_valid_in_reset)
    else begin
        assert_errors++;
        $error("avg_valid high during soft reset");
    end

    a_source_holds: assert property (p_source_holds)
    else begin
        assert_errors++;
        $error("soft_reset low after a reset source");
    end

endmodule

bind core_profiler core_profiler_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .wdreset    (wdreset),
    .bus_err    (bus_err),
    .soft_reset (soft_reset),
    .avg_valid  (avg_valid)
);

// ==== source/core_profiler.sv ====
// multi-core activity profiler
// top level

`timescale 1ns/1ps

module core_profiler (
    input  clk,
    input  reset,
    input  wdreset,
    input  bus_err,
    input  profiler_pkg::core_mask_t bus_sel,
    input  profiler_pkg::core_mask_t fetch_sel,
    input  profiler_pkg::core_mask_t halt,
    output logic soft_reset,
    output logic all_halted,
    output logic avg_valid,
    output profiler_pkg::count_t bus_time_avg,
    output profiler_pkg::count_t bus_req_avg,
    output profiler_pkg::count_t fetch_time_avg,
    output profiler_pkg::count_t work_time_avg
);
    import profiler_pkg::*;

    // sampler to counters
    core_mask_t bus_cyc;
    core_mask_t req_edge;
    core_mask_t fetch_cyc;
    core_mask_t work_cyc;

    // counters to averaging
    count_t [CORES-1:0] bus_counts;
    count_t [CORES-1:0] req_counts;
    count_t [CORES-1:0] fetch_counts;
    count_t [CORES-1:0] work_counts;
    logic               snapshot;

    // merged and stretched reset, drives every later stage
    reset_hold u_reset_hold (
        .clk        (clk),
        .reset      (reset),
        .wdreset    (wdreset),
        .bus_err    (bus_err),
        .soft_reset (soft_reset)
    );

    activity_sampler u_sampler (
        .clk        (clk),
        .reset      (soft_reset),
        .bus_sel    (bus_sel),
        .fetch_sel  (fetch_sel),
        .halt       (halt),
        .bus_cyc    (bus_cyc),
        .req_edge   (req_edge),
        .fetch_cyc  (fetch_cyc),
        .work_cyc   (work_cyc),
        .halted_all (all_halted)
    );

    activity_counters u_counters (
        .clk          (clk),
        .reset        (soft_reset),
        .bus_cyc      (bus_cyc),
        .req_edge     (req_edge),
        .fetch_cyc    (fetch_cyc),
        .work_cyc     (work_cyc),
        .halted_all   (all_halted),
        .bus_counts   (bus_counts),
        .req_counts   (req_counts),
        .fetch_counts (fetch_counts),
        .work_counts  (work_counts),
        .snapshot     (snapshot)
    );

    average_unit u_average (
        .clk            (clk),
        .reset          (soft_reset),
        .snapshot       (snapshot),
        .bus_counts     (bus_counts),
        .req_counts     (req_counts),
        .fetch_counts   (fetch_counts),
        .work_counts    (work_counts),
        .bus_time_avg   (bus_time_avg),
        .bus_req_avg    (bus_req_avg),
        .fetch_time_avg (fetch_time_avg),
        .work_time_avg  (work_time_avg),
        .avg_valid      (avg_valid)
    );

endmodule

// ==== source/average_unit.sv ====
// cross-core averaging of the activity counters

`timescale 1ns/1ps

module average_unit (
    input  clk,
    input  reset,
    input  snapshot,
    input  profiler_pkg::count_t [profiler_pkg::CORES-1:0] bus_counts,
    input  profiler_pkg::count_t [profiler_pkg::CORES-1:0] req_counts,
    input  profiler_pkg::count_t [profiler_pkg::CORES-1:0] fetch_counts,
    input  profiler_pkg::count_t [profiler_pkg::CORES-1:0] work_counts,
    output profiler_pkg::count_t bus_time_avg,
    output profiler_pkg::count_t bus_req_avg,
    output profiler_pkg::count_t fetch_time_avg,
    output profiler_pkg::count_t work_time_avg,
    output logic avg_valid
);
    import profiler_pkg::*;

    sum_t bus_sum;
    sum_t req_sum;
    sum_t fetch_sum;
    sum_t work_sum;

    // full-width sum so nothing is lost before the shift
    function automatic sum_t sum_counts(input count_t [CORES-1:0] counts);
        sum_t acc;
        acc = '0;
        for (int k = 0; k < CORES; k++) begin
            acc = acc + sum_t'(counts[k]);
        end
        return acc;
    endfunction

    assign bus_sum   = sum_counts(bus_counts);
    assign req_sum   = sum_counts(req_counts);
    assign fetch_sum = sum_counts(fetch_counts);
    assign work_sum  = sum_counts(work_counts);

    //////////////////////////////////////////////////
    // floor average, upper COUNT_W bits of each sum
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_time_avg   <= '0;
            bus_req_avg    <= '0;
            fetch_time_avg <= '0;
            work_time_avg  <= '0;
            avg_valid      <= 1'b0;
        end
        else begin
            avg_valid <= snapshot;
            // held until the next snapshot
            if (snapshot) begin
                bus_time_avg   <= bus_sum[CORE_BITS +: COUNT_W];
                bus_req_avg    <= req_sum[CORE_BITS +: COUNT_W];
                fetch_time_avg <= fetch_sum[CORE_BITS +: COUNT_W];
                work_time_avg  <= work_sum[CORE_BITS +: COUNT_W];
            end
        end
    end

endmodule

// ==== source/activity_counters.sv ====
// per-core activity counters

`timescale 1ns/1ps

module activity_counters (
    input  clk,
    input  reset,
    input  profiler_pkg::core_mask_t bus_cyc,
    input  profiler_pkg::core_mask_t req_edge,
    input  profiler_pkg::core_mask_t fetch_cyc,
    input  profiler_pkg::core_mask_t work_cyc,
    input  halted_all,
    output profiler_pkg::count_t [profiler_pkg::CORES-1:0] bus_counts,
    output profiler_pkg::count_t [profiler_pkg::CORES-1:0] req_counts,
    output profiler_pkg::count_t [profiler_pkg::CORES-1:0] fetch_counts,
    output profiler_pkg::count_t [profiler_pkg::CORES-1:0] work_counts,
    output logic snapshot
);
    import profiler_pkg::*;

    // halted_all one cycle back
    logic halted_d;

    //////////////////////////////////////////////////
    // counters, four per core
    //////////////////////////////////////////////////

    for (genvar i = 0; i < CORES; i++) begin : g_core
        count_t bus_q;
        count_t req_q;
        count_t fetch_q;
        count_t work_q;

        // each counter steps on its own strobe bit, wraps at COUNT_W
        always_ff @(posedge clk) begin
            if (reset) begin
                bus_q   <= '0;
                req_q   <= '0;
                fetch_q <= '0;
                work_q  <= '0;
            end
            else begin
                if (bus_cyc[i]) begin
                    bus_q <= bus_q + 1'b1;
                end
                if (req_edge[i]) begin
                    req_q <= req_q + 1'b1;
                end
                if (fetch_cyc[i]) begin
                    fetch_q <= fetch_q + 1'b1;
                end
                if (work_cyc[i]) begin
                    work_q <= work_q + 1'b1;
                end
            end
        end

        assign bus_counts[i]   = bus_q;
        assign req_counts[i]   = req_q;
        assign fetch_counts[i] = fetch_q;
        assign work_counts[i]  = work_q;
    end

    //////////////////////////////////////////////////
    // snapshot on the all-halted rising edge
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            halted_d <= 1'b0;
            snapshot <= 1'b0;
        end
        else begin
            halted_d <= halted_all;
            // counts of the halting cycle land on this same edge
            snapshot <= halted_all & ~halted_d;
        end
    end

endmodule

// ==== source/activity_sampler.sv ====
// per-core activity sampler

`timescale 1ns/1ps

module activity_sampler (
    input  clk,
    input  reset,
    input  profiler_pkg::core_mask_t bus_sel,
    input  profiler_pkg::core_mask_t fetch_sel,
    input  profiler_pkg::core_mask_t halt,
    output profiler_pkg::core_mask_t bus_cyc,
    output profiler_pkg::core_mask_t req_edge,
    output profiler_pkg::core_mask_t fetch_cyc,
    output profiler_pkg::core_mask_t work_cyc,
    output logic halted_all
);
    import profiler_pkg::*;

    // bus select of the previous cycle, for request edges
    core_mask_t bus_prev;
    core_mask_t idle;

    // no bus, no fetch and not halted
    assign idle = ~(bus_sel | fetch_sel | halt);

    //////////////////////////////////////////////////
    // one cycle of latency for every class
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_prev   <= '0;
            bus_cyc    <= '0;
            req_edge   <= '0;
            fetch_cyc  <= '0;
            work_cyc   <= '0;
            halted_all <= 1'b0;
        end
        else begin
            bus_prev  <= bus_sel;
            bus_cyc   <= bus_sel;
            // new request, select just went high
            req_edge  <= bus_sel & ~bus_prev;
            fetch_cyc <= fetch_sel;
            work_cyc  <= idle;
            // level, all cores halted in this cycle
            halted_all <= &halt;
        end
    end

endmodule

// ==== source/reset_hold.sv ====
// soft reset stretcher

`timescale 1ns/1ps

module reset_hold (
    input  clk,
    input  reset,
    input  wdreset,
    input  bus_err,
    output logic soft_reset
);
    import profiler_pkg::*;

    hold_t hold;
    logic  reload;

    // any source restarts the hold window
    assign reload = reset | wdreset | bus_err;

    always_ff @(posedge clk) begin
        if (reload) begin
            hold <= hold_t'(HOLD_CYCLES - 1);
        end
        else if (hold != '0) begin
            hold <= hold - 1'b1;
        end
    end

    // high for the whole count down
    assign soft_reset = (hold != '0);

endmodule

// ==== source/profiler_pkg.sv ====
// core profiler shared definitions

package profiler_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // profiled cores, kept a power of two so the average is a shift
    localparam int CORES = 4;
    localparam int CORE_BITS = $clog2(CORES);

    // activity counter and average width
    localparam int COUNT_W = 16;

    // reset hold length, soft reset outlasts its sources by HOLD_CYCLES-1
    localparam int HOLD_CYCLES = 8;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // one bit per core
    typedef logic [CORES-1:0] core_mask_t;

    // single counter or average value
    typedef logic [COUNT_W-1:0] count_t;

    // one counter summed over all cores
    typedef logic [COUNT_W+CORE_BITS-1:0] sum_t;

    // reset hold down-counter
    typedef logic [$clog2(HOLD_CYCLES)-1:0] hold_t;

endpackage
